/* hw/mm_ctrl_pkg.sv */
package mm_ctrl_pkg;

    // ============================================================
    // array geometry and widths
    // ============================================================
    localparam int ARRAY_N    = 8;
    localparam int ARRAY_M    = 8;
    localparam int ROW_SHIFT  = $clog2(ARRAY_N);
    localparam int COL_SHIFT  = $clog2(ARRAY_M);
    localparam int TILE_ELEMS = ARRAY_N * ARRAY_M;

    localparam int BUF_ADDR_W = 10;
    localparam int DIM_W      = 16;
    localparam int SP_WORD_W  = 32;
    localparam int SP_ADDR_W  = 32;
    // holds 0..ARRAY_N
    localparam int SIZE_W     = 4;

    localparam int CLEAR_CYCLES = 4;
    localparam int FIFO_DEPTH   = 4;
    localparam int FIFO_PTR_W   = $clog2(FIFO_DEPTH);

    // ============================================================
    // types
    // ============================================================
    typedef logic [SP_WORD_W-1:0]  sp_word_t;
    typedef logic [SP_ADDR_W-1:0]  sp_addr_t;
    typedef logic [DIM_W-1:0]      dim_t;
    typedef logic [BUF_ADDR_W-1:0] buf_addr_t;
    typedef logic [SIZE_W-1:0]     tile_size_t;

    // opcode seen by the systolic array
    typedef enum logic [2:0] {
        OP_IDLE    = 3'b000,
        OP_COMPUTE = 3'b100,
        OP_DRAIN   = 3'b110
    } array_op_t;

    // one result tile, as queued between sequencer and phase control
    typedef struct packed {
        buf_addr_t  a_base;
        buf_addr_t  w_base;
        buf_addr_t  o_base;
        tile_size_t rows;
        tile_size_t cols;
        logic       last;
    } tile_cmd_t;

    // ============================================================
    // configuration BRAM map, byte addresses
    // ============================================================
    localparam sp_addr_t SP_ADDR_START = 32'd0;
    localparam sp_addr_t SP_ADDR_M     = 32'd8;
    localparam sp_addr_t SP_ADDR_K     = 32'd12;
    localparam sp_addr_t SP_ADDR_N     = 32'd16;
    localparam sp_addr_t SP_ADDR_DONE  = 32'd100;

endpackage

/* hw/cfg_if.sv */
interface cfg_if
    import mm_ctrl_pkg::*;
();

    // one-cycle pulse, the rest holds until the next run
    logic cfg_start;
    dim_t m;
    dim_t k;
    dim_t n;
    dim_t tiles_m;
    dim_t tiles_n;

    modport source (
        output cfg_start, m, k, n, tiles_m, tiles_n
    );

    modport sink (
        input cfg_start, m, k, n, tiles_m, tiles_n
    );

endinterface

/* hw/tile_cmd_if.sv */
interface tile_cmd_if
    import mm_ctrl_pkg::*;
();

    logic      push;
    logic      full;
    logic      pop;
    logic      empty;
    tile_cmd_t cmd;

    // write side of the queue
    modport producer (output push, cmd, input full);
    modport fifo_in  (input push, cmd, output full);

    // read side, cmd is the head entry
    modport fifo_out (output cmd, empty, input pop);
    modport consumer (input cmd, empty, output pop);

endinterface

/* hw/config_loader.sv */
module config_loader
    import mm_ctrl_pkg::*;
(
    input  logic     clk,
    input  logic     i_rst_n,
    input  sp_word_t i_sp_rdata,
    output sp_addr_t o_sp_addr,
    output logic     o_sp_en,
    output logic     o_sp_we,
    output sp_word_t o_sp_wdata,
    input  logic     i_run_done,
    output logic     o_busy,
    cfg_if.source    cfg
);

    typedef enum logic [2:0] {
        LD_IDLE,
        LD_FETCH,
        LD_CALC,
        LD_RUN,
        LD_FLAG,
        LD_CLEAR
    } ld_state_t;

    ld_state_t  state;
    // 0 = address out, 1 = read data back
    logic       rd_phase;
    logic [1:0] word_idx;
    logic       start_hit;
    logic       word_done;

    assign start_hit = (state == LD_IDLE) && o_sp_en && rd_phase && (i_sp_rdata != '0);
    assign word_done = (state == LD_FETCH) && rd_phase;

    function automatic dim_t round_up_tiles(input dim_t dim, input int shift);
        logic [DIM_W:0] padded;
        padded = {1'b0, dim} + {1'b0, dim_t'((1 << shift) - 1)};
        return dim_t'(padded >> shift);
    endfunction

    // ============================================================
    // control FSM
    // ============================================================
    always_ff @(posedge clk)
    begin
        if (!i_rst_n)
        begin
            state         <= LD_IDLE;
            rd_phase      <= 1'b0;
            word_idx      <= '0;
            o_sp_en       <= 1'b0;
            o_sp_we       <= 1'b0;
            o_busy        <= 1'b0;
            cfg.cfg_start <= 1'b0;
        end
        else
        begin
            cfg.cfg_start <= 1'b0;
            case (state)
                LD_IDLE:
                begin
                    o_sp_en  <= 1'b1;
                    word_idx <= '0;
                    // poll only once the BRAM port is enabled
                    if (o_sp_en)
                        rd_phase <= ~rd_phase;
                    if (start_hit)
                        state <= LD_FETCH;
                end
                LD_FETCH:
                begin
                    rd_phase <= ~rd_phase;
                    if (word_done)
                    begin
                        word_idx <= word_idx + 1'b1;
                        if (word_idx == 2'd2)
                            state <= LD_CALC;
                    end
                end
                LD_CALC:
                begin
                    o_sp_en       <= 1'b0;
                    o_busy        <= 1'b1;
                    cfg.cfg_start <= 1'b1;
                    state         <= LD_RUN;
                end
                LD_RUN:
                begin
                    if (i_run_done)
                    begin
                        o_busy  <= 1'b0;
                        o_sp_en <= 1'b1;
                        o_sp_we <= 1'b1;
                        state   <= LD_FLAG;
                    end
                end
                LD_FLAG:
                begin
                    state <= LD_CLEAR;
                end
                default:
                begin
                    // second host write done, back to polling
                    o_sp_we <= 1'b0;
                    state   <= LD_IDLE;
                end
            endcase
        end
    end

    // ============================================================
    // address, write data and captured sizes
    // ============================================================
    always_ff @(posedge clk)
    begin
        case (state)
            LD_IDLE:
            begin
                o_sp_addr <= start_hit ? SP_ADDR_M : SP_ADDR_START;
            end
            LD_FETCH:
            begin
                if (word_done)
                begin
                    case (word_idx)
                        2'd0:
                        begin
                            cfg.m     <= dim_t'(i_sp_rdata);
                            o_sp_addr <= SP_ADDR_K;
                        end
                        2'd1:
                        begin
                            cfg.k     <= dim_t'(i_sp_rdata);
                            o_sp_addr <= SP_ADDR_N;
                        end
                        default:
                        begin
                            cfg.n     <= dim_t'(i_sp_rdata);
                            o_sp_addr <= SP_ADDR_START;
                        end
                    endcase
                end
            end
            LD_CALC:
            begin
                cfg.tiles_m <= round_up_tiles(cfg.m, ROW_SHIFT);
                cfg.tiles_n <= round_up_tiles(cfg.n, COL_SHIFT);
            end
            LD_RUN:
            begin
                // done flag for the host
                if (i_run_done)
                begin
                    o_sp_addr  <= SP_ADDR_DONE;
                    o_sp_wdata <= sp_word_t'(1);
                end
            end
            LD_FLAG:
            begin
                o_sp_addr  <= SP_ADDR_START;
                o_sp_wdata <= '0;
            end
            default:
            begin
                o_sp_addr <= SP_ADDR_START;
            end
        endcase
    end

endmodule

/* hw/tile_sequencer.sv */
module tile_sequencer
    import mm_ctrl_pkg::*;
(
    input  logic         clk,
    input  logic         i_rst_n,
    cfg_if.sink          cfg,
    tile_cmd_if.producer q
);

    logic      active;
    dim_t      row_idx;
    dim_t      col_idx;
    buf_addr_t a_base;
    buf_addr_t w_base;
    buf_addr_t o_base;
    logic      last_row;
    logic      last_col;
    logic      do_push;
    tile_cmd_t cmd_next;

    assign last_row = (row_idx == cfg.tiles_m - 1'b1);
    assign last_col = (col_idx == cfg.tiles_n - 1'b1);
    assign do_push  = active && !q.full;

    // edge tiles carry the remainder of M or N
    always_comb
    begin
        cmd_next.a_base = a_base;
        cmd_next.w_base = w_base;
        cmd_next.o_base = o_base;
        if (last_row && (cfg.m[ROW_SHIFT-1:0] != '0))
            cmd_next.rows = tile_size_t'(cfg.m[ROW_SHIFT-1:0]);
        else
            cmd_next.rows = tile_size_t'(ARRAY_N);
        if (last_col && (cfg.n[COL_SHIFT-1:0] != '0))
            cmd_next.cols = tile_size_t'(cfg.n[COL_SHIFT-1:0]);
        else
            cmd_next.cols = tile_size_t'(ARRAY_M);
        cmd_next.last = last_row && last_col;
    end

    assign q.push = do_push;
    assign q.cmd  = cmd_next;

    // ============================================================
    // grid walk, column tile outer, row tile inner
    // ============================================================
    always_ff @(posedge clk)
    begin
        if (!i_rst_n)
        begin
            active  <= 1'b0;
            row_idx <= '0;
            col_idx <= '0;
            a_base  <= '0;
            w_base  <= '0;
            o_base  <= '0;
        end
        else if (cfg.cfg_start)
        begin
            active  <= 1'b1;
            row_idx <= '0;
            col_idx <= '0;
            a_base  <= '0;
            w_base  <= '0;
            o_base  <= '0;
        end
        else if (do_push)
        begin
            o_base <= o_base + buf_addr_t'(TILE_ELEMS);
            if (cmd_next.last)
            begin
                active <= 1'b0;
            end
            else if (last_row)
            begin
                // new column, A restarts from the top
                row_idx <= '0;
                col_idx <= col_idx + 1'b1;
                a_base  <= '0;
                w_base  <= w_base + buf_addr_t'(cfg.k);
            end
            else
            begin
                row_idx <= row_idx + 1'b1;
                a_base  <= a_base + buf_addr_t'(cfg.k);
            end
        end
    end

endmodule

/* hw/tile_cmd_fifo.sv */
module tile_cmd_fifo
    import mm_ctrl_pkg::*;
(
    input  logic         clk,
    input  logic         i_rst_n,
    tile_cmd_if.fifo_in  wr,
    tile_cmd_if.fifo_out rd
);

    tile_cmd_t             mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_PTR_W:0]   count;
    logic                  do_push;
    logic                  do_pop;

    assign wr.full  = (count == (FIFO_PTR_W + 1)'(FIFO_DEPTH));
    assign rd.empty = (count == '0);
    assign do_push  = wr.push && !wr.full;
    assign do_pop   = rd.pop && !rd.empty;
    assign rd.cmd   = mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (do_push)
            mem[wr_ptr] <= wr.cmd;
    end

    // pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk)
    begin
        if (!i_rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* hw/tile_phase_ctrl.sv */
module tile_phase_ctrl
    import mm_ctrl_pkg::*;
(
    input  logic         clk,
    input  logic         i_rst_n,
    input  dim_t         i_k,
    tile_cmd_if.consumer q,
    output logic         o_a_buf_on,
    output logic         o_w_buf_on,
    output buf_addr_t    o_a_base_addr,
    output buf_addr_t    o_w_base_addr,
    output buf_addr_t    o_o_base_addr,
    output tile_size_t   o_num_rows,
    output tile_size_t   o_num_cols,
    output array_op_t    o_array_op,
    output logic         o_o_ag_on,
    output logic         o_array_clear,
    output logic         o_run_done
);

    typedef enum logic [2:0] {
        PH_IDLE,
        PH_FEED,
        PH_SETTLE,
        PH_DRAIN_WAIT,
        PH_STORE,
        PH_CLEAR
    } phase_t;

    phase_t    state;
    dim_t      cyc;
    dim_t      last_cyc;
    dim_t      rows_w;
    dim_t      cols_w;
    logic      phase_end;
    logic      take_cmd;
    tile_cmd_t cur;

    assign rows_w = dim_t'(cur.rows);
    assign cols_w = dim_t'(cur.cols);

    // ============================================================
    // phase lengths, as last counter value
    // ============================================================
    always_comb
    begin
        case (state)
            PH_FEED:       last_cyc = i_k - 1'b1;
            PH_SETTLE:     last_cyc = rows_w + cols_w - 2'd2;
            // rows below the tile still have to drain past it
            PH_DRAIN_WAIT: last_cyc = dim_t'(ARRAY_N) - rows_w - 1'b1;
            PH_STORE:      last_cyc = rows_w + 1'b1;
            PH_CLEAR:      last_cyc = dim_t'(CLEAR_CYCLES - 1);
            default:       last_cyc = '0;
        endcase
    end

    assign phase_end = (cyc == last_cyc);
    // pick up the next tile straight out of clear
    assign take_cmd  = !q.empty && ((state == PH_IDLE) || ((state == PH_CLEAR) && phase_end));
    assign q.pop     = take_cmd;

    always_ff @(posedge clk)
    begin
        if (!i_rst_n)
        begin
            state <= PH_IDLE;
            cyc   <= '0;
        end
        else if (take_cmd)
        begin
            state <= PH_FEED;
            cyc   <= '0;
        end
        else if ((state != PH_IDLE) && phase_end)
        begin
            cyc <= '0;
            case (state)
                PH_FEED:
                    state <= PH_SETTLE;
                PH_SETTLE:
                    state <= (cur.rows == tile_size_t'(ARRAY_N)) ? PH_STORE : PH_DRAIN_WAIT;
                PH_DRAIN_WAIT:
                    state <= PH_STORE;
                PH_STORE:
                    state <= PH_CLEAR;
                default:
                    state <= PH_IDLE;
            endcase
        end
        else if (state != PH_IDLE)
        begin
            cyc <= cyc + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (take_cmd)
            cur <= q.cmd;
    end

    // ============================================================
    // array and buffer controls
    // ============================================================
    always_comb
    begin
        case (state)
            PH_FEED, PH_SETTLE:      o_array_op = OP_COMPUTE;
            PH_DRAIN_WAIT, PH_STORE: o_array_op = OP_DRAIN;
            default:                 o_array_op = OP_IDLE;
        endcase
    end

    assign o_a_buf_on    = (state == PH_FEED);
    assign o_w_buf_on    = (state == PH_FEED);
    assign o_o_ag_on     = (state == PH_STORE);
    assign o_array_clear = (state == PH_CLEAR) && phase_end;
    assign o_run_done    = (state == PH_CLEAR) && phase_end && cur.last;

    assign o_a_base_addr = cur.a_base;
    assign o_w_base_addr = cur.w_base;
    assign o_o_base_addr = cur.o_base;
    assign o_num_rows    = cur.rows;
    assign o_num_cols    = cur.cols;

endmodule

/* hw/mm_ctrl_top.sv */
module mm_ctrl_top
    import mm_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       i_rst_n,
    input  sp_word_t   i_sp_rdata,
    output sp_addr_t   o_sp_addr,
    output logic       o_sp_en,
    output logic       o_sp_we,
    output sp_word_t   o_sp_wdata,
    output logic       o_a_buf_on,
    output logic       o_w_buf_on,
    output buf_addr_t  o_a_base_addr,
    output buf_addr_t  o_w_base_addr,
    output buf_addr_t  o_o_base_addr,
    output tile_size_t o_num_rows,
    output tile_size_t o_num_cols,
    output array_op_t  o_array_op,
    output logic       o_o_ag_on,
    output logic       o_array_clear,
    output logic       o_busy
);

    logic run_done;

    cfg_if      cfg_bus ();
    tile_cmd_if seq_q ();
    tile_cmd_if q_phase ();

    config_loader config_loader_inst (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_sp_rdata (i_sp_rdata),
        .o_sp_addr  (o_sp_addr),
        .o_sp_en    (o_sp_en),
        .o_sp_we    (o_sp_we),
        .o_sp_wdata (o_sp_wdata),
        .i_run_done (run_done),
        .o_busy     (o_busy),
        .cfg        (cfg_bus.source)
    );

    tile_sequencer tile_sequencer_inst (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .cfg     (cfg_bus.sink),
        .q       (seq_q.producer)
    );

    tile_cmd_fifo tile_cmd_fifo_inst (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .wr      (seq_q.fifo_in),
        .rd      (q_phase.fifo_out)
    );

    tile_phase_ctrl tile_phase_ctrl_inst (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_k           (cfg_bus.k),
        .q             (q_phase.consumer),
        .o_a_buf_on    (o_a_buf_on),
        .o_w_buf_on    (o_w_buf_on),
        .o_a_base_addr (o_a_base_addr),
        .o_w_base_addr (o_w_base_addr),
        .o_o_base_addr (o_o_base_addr),
        .o_num_rows    (o_num_rows),
        .o_num_cols    (o_num_cols),
        .o_array_op    (o_array_op),
        .o_o_ag_on     (o_o_ag_on),
        .o_array_clear (o_array_clear),
        .o_run_done    (run_done)
    );

endmodule

/* verification/tb_clock_gen.sv */
module tb_clock_gen (
    output logic o_clk,
    output logic o_rst_n
);

    timeunit 1ns;
    timeprecision 100ps;

    // 10 ns period
    initial
    begin
        o_clk = 1'b0;
        forever #5 o_clk = ~o_clk;
    end

    // reset held low for 8 rising edges, released just after an edge
    initial
    begin
        o_rst_n = 1'b0;
        repeat (8) @(posedge o_clk);
        #1;
        o_rst_n = 1'b1;
    end

endmodule

/* verification/mm_ctrl_tb.sv */
module mm_ctrl_tb
    import mm_ctrl_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    logic       clk;
    logic       rst_n;
    sp_word_t   sp_rdata;
    sp_addr_t   sp_addr;
    logic       sp_en;
    logic       sp_we;
    sp_word_t   sp_wdata;
    logic       a_buf_on;
    logic       w_buf_on;
    buf_addr_t  a_base_addr;
    buf_addr_t  w_base_addr;
    buf_addr_t  o_base_addr;
    tile_size_t num_rows;
    tile_size_t num_cols;
    array_op_t  array_op;
    logic       o_ag_on;
    logic       array_clear;
    logic       busy;

    // word-addressed model of the configuration BRAM
    sp_word_t    mem [32];
    sp_addr_t    bram_addr;
    logic        bram_en;
    logic        bram_we;
    sp_word_t    bram_wdata;
    tile_cmd_t   exp_tiles [$];
    logic [15:0] lfsr_state;
    int          error_count;

    tb_clock_gen tb_clock_gen_inst (
        .o_clk   (clk),
        .o_rst_n (rst_n)
    );

    mm_ctrl_top mm_ctrl_top_inst (
        .clk           (clk),
        .i_rst_n       (rst_n),
        .i_sp_rdata    (sp_rdata),
        .o_sp_addr     (sp_addr),
        .o_sp_en       (sp_en),
        .o_sp_we       (sp_we),
        .o_sp_wdata    (sp_wdata),
        .o_a_buf_on    (a_buf_on),
        .o_w_buf_on    (w_buf_on),
        .o_a_base_addr (a_base_addr),
        .o_w_base_addr (w_base_addr),
        .o_o_base_addr (o_base_addr),
        .o_num_rows    (num_rows),
        .o_num_cols    (num_cols),
        .o_array_op    (array_op),
        .o_o_ag_on     (o_ag_on),
        .o_array_clear (array_clear),
        .o_busy        (busy)
    );

    function automatic int word_index(input sp_addr_t addr);
        return int'(addr[6:2]);
    endfunction

    // one cycle of read latency and write-first on the same address
    always @(posedge clk)
    begin
        bram_addr  = sp_addr;
        bram_en    = sp_en;
        bram_we    = sp_we;
        bram_wdata = sp_wdata;
        #1;
        if (bram_we)
            mem[word_index(bram_addr)] = bram_wdata;
        if (bram_en)
            sp_rdata = mem[word_index(bram_addr)];
    end

    // ============================================================
    // error reporting and compare tasks
    // ============================================================
    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_problem(input string msg);
        error_count++;
        $display("ERROR: %s", msg);
        abort_run();
    endtask

    task automatic check_addr(input string name, input buf_addr_t expected,
                              input buf_addr_t actual);
        if (expected !== actual)
        begin
            error_count++;
            $display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_size(input string name, input tile_size_t expected,
                              input tile_size_t actual);
        if (expected !== actual)
        begin
            error_count++;
            $display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (expected != actual)
        begin
            error_count++;
            $display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_op(input string name, input array_op_t expected,
                            input array_op_t actual);
        if (expected !== actual)
        begin
            error_count++;
            $display("FAILED %s: expected %03b, actual %03b", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_word(input string name, input sp_word_t expected,
                              input sp_word_t actual);
        if (expected !== actual)
        begin
            error_count++;
            $display("FAILED %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (expected !== actual)
        begin
            error_count++;
            $display("FAILED %s: expected %b, actual %b", name, expected, actual);
            abort_run();
        end
    endtask

    // ============================================================
    // random sizes and reference model
    // ============================================================
    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    task automatic take_bits(input int nbits, output int value);
        value = 0;
        for (int i = 0; i < nbits; i++)
        begin
            value      = (value << 1) | int'(lfsr_state[15]);
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // column tiles outer and row tiles inner
    task automatic build_model(input int m, input int k, input int n);
        int        tiles_m;
        int        tiles_n;
        int        idx;
        tile_cmd_t tile;
        tiles_m = (m + ARRAY_N - 1) / ARRAY_N;
        tiles_n = (n + ARRAY_M - 1) / ARRAY_M;
        idx     = 0;
        exp_tiles.delete();
        for (int c = 0; c < tiles_n; c++)
        begin
            for (int r = 0; r < tiles_m; r++)
            begin
                tile.a_base = buf_addr_t'(r * k);
                tile.w_base = buf_addr_t'(c * k);
                tile.o_base = buf_addr_t'(idx * ARRAY_N * ARRAY_M);
                if ((r == tiles_m - 1) && (m % ARRAY_N != 0))
                    tile.rows = tile_size_t'(m % ARRAY_N);
                else
                    tile.rows = tile_size_t'(ARRAY_N);
                if ((c == tiles_n - 1) && (n % ARRAY_M != 0))
                    tile.cols = tile_size_t'(n % ARRAY_M);
                else
                    tile.cols = tile_size_t'(ARRAY_M);
                tile.last = (r == tiles_m - 1) && (c == tiles_n - 1);
                exp_tiles.push_back(tile);
                idx++;
            end
        end
    endtask

    // ============================================================
    // one run with host writes and output monitor
    // ============================================================
    task automatic run_matmul(input string name, input int m, input int k, input int n);
        int        guard;
        int        run_cyc;
        int        feed_pos;
        int        clear_pos;
        int        gap_len;
        int        store_len;
        int        tiles_seen;
        int        exp_gap;
        logic      feed_next;
        logic      prev_a;
        logic      prev_ag;
        logic      in_gap;
        tile_cmd_t exp_tile;
        $display("%s: M=%0d K=%0d N=%0d", name, m, k, n);
        build_model(m, k, n);
        mem[word_index(SP_ADDR_M)]     = sp_word_t'(m);
        mem[word_index(SP_ADDR_K)]     = sp_word_t'(k);
        mem[word_index(SP_ADDR_N)]     = sp_word_t'(n);
        mem[word_index(SP_ADDR_DONE)]  = '0;
        mem[word_index(SP_ADDR_START)] = sp_word_t'(1);

        guard = 0;
        while (!busy)
        begin
            @(negedge clk);
            guard++;
            if (guard > 100)
                report_problem({name, ": o_busy never rose after the start word was set"});
        end

        prev_a     = 1'b0;
        prev_ag    = 1'b0;
        in_gap     = 1'b0;
        feed_next  = 1'b0;
        feed_pos   = 0;
        clear_pos  = 0;
        gap_len    = 0;
        store_len  = 0;
        tiles_seen = 0;
        exp_tile   = '0;
        run_cyc    = 0;
        while (busy)
        begin
            // first feed 3 cycles after cfg_start, later feeds straight out of clear
            if ((run_cyc == 3) || (feed_next && (tiles_seen < exp_tiles.size())))
                feed_pos = 1;
            else if (feed_pos != 0)
                feed_pos = (feed_pos < k) ? feed_pos + 1 : 0;
            check_bit({name, " a_buf_on"}, feed_pos != 0, a_buf_on);
            check_bit({name, " w_buf_on"}, feed_pos != 0, w_buf_on);
            if (feed_pos != 0)
                check_op({name, " op during feed"}, OP_COMPUTE, array_op);
            if (prev_a && !a_buf_on)
            begin
                in_gap  = 1'b1;
                gap_len = 0;
            end
            if (in_gap && !o_ag_on)
                gap_len++;
            if (o_ag_on && !prev_ag)
            begin
                if (tiles_seen >= exp_tiles.size())
                    report_problem({name, ": more tiles were stored than the grid holds"});
                exp_tile = exp_tiles[tiles_seen];
                // settle then drain wait for the rows below the tile
                exp_gap  = int'(exp_tile.rows) + int'(exp_tile.cols) - 1
                         + ARRAY_N - int'(exp_tile.rows);
                check_count($sformatf("%s tile %0d gap", name, tiles_seen), exp_gap, gap_len);
                check_addr($sformatf("%s tile %0d a_base", name, tiles_seen),
                           exp_tile.a_base, a_base_addr);
                check_addr($sformatf("%s tile %0d w_base", name, tiles_seen),
                           exp_tile.w_base, w_base_addr);
                check_addr($sformatf("%s tile %0d o_base", name, tiles_seen),
                           exp_tile.o_base, o_base_addr);
                check_size($sformatf("%s tile %0d rows", name, tiles_seen),
                           exp_tile.rows, num_rows);
                check_size($sformatf("%s tile %0d cols", name, tiles_seen),
                           exp_tile.cols, num_cols);
                in_gap    = 1'b0;
                store_len = 0;
            end
            if (o_ag_on)
            begin
                check_op({name, " op during store"}, OP_DRAIN, array_op);
                store_len++;
            end
            if (prev_ag && !o_ag_on)
            begin
                check_count($sformatf("%s tile %0d store length", name, tiles_seen),
                            int'(exp_tile.rows) + 2, store_len);
                tiles_seen++;
                clear_pos = 1;
            end
            else if (clear_pos != 0)
            begin
                clear_pos = (clear_pos < CLEAR_CYCLES) ? clear_pos + 1 : 0;
            end
            if (clear_pos != 0)
                check_op({name, " op during clear"}, OP_IDLE, array_op);
            // clear pulse only in the last cycle of the clear phase
            check_bit({name, " o_array_clear"}, clear_pos == CLEAR_CYCLES, array_clear);
            feed_next = (clear_pos == CLEAR_CYCLES);
            prev_a    = a_buf_on;
            prev_ag   = o_ag_on;
            @(negedge clk);
            run_cyc++;
            if (run_cyc > 3000)
                report_problem({name, ": run did not finish, o_busy stayed high"});
        end
        check_count({name, " tile count"},
                    ((m + ARRAY_N - 1) / ARRAY_N) * ((n + ARRAY_M - 1) / ARRAY_M), tiles_seen);

        // wait out the done flag write and the start word clear
        guard = 0;
        while (sp_we)
        begin
            @(negedge clk);
            guard++;
            if (guard > 20)
                report_problem({name, ": done handshake with the configuration BRAM stalled"});
        end
        check_word({name, " done flag"}, sp_word_t'(1), mem[word_index(SP_ADDR_DONE)]);
        check_word({name, " start word"}, '0, mem[word_index(SP_ADDR_START)]);
        check_bit({name, " o_busy after run"}, 1'b0, busy);
    endtask

    // ============================================================
    // test sequence
    // ============================================================
    initial
    begin
        int m;
        int k;
        int n;
        int guard;
        lfsr_state  = 16'd21;
        error_count = 0;
        sp_rdata    = '0;
        for (int i = 0; i < 32; i++)
            mem[i] = '0;

        guard = 0;
        while (rst_n !== 1'b1)
        begin
            @(negedge clk);
            guard++;
            if (guard > 50)
                report_problem("reset was never released");
        end

        // start word held at zero
        for (int c = 0; c < 200; c++)
        begin
            @(negedge clk);
            if (busy || o_ag_on || sp_we)
                report_problem("o_busy, o_o_ag_on or o_sp_we went high with no start word");
        end

        run_matmul("edge tiles", 13, 5, 19);
        run_matmul("full tiles", 16, 3, 8);
        for (int r = 0; r < 5; r++)
        begin
            take_bits(5, m);
            m = m % 20 + 1;
            take_bits(4, k);
            k = k % 12 + 1;
            take_bits(5, n);
            n = n % 20 + 1;
            run_matmul($sformatf("random run %0d", r), m, k, n);
        end

        if (error_count == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

/* mm_ctrl_top.f */
hw/mm_ctrl_pkg.sv
hw/cfg_if.sv
hw/tile_cmd_if.sv
hw/config_loader.sv
hw/tile_sequencer.sv
hw/tile_cmd_fifo.sv
hw/tile_phase_ctrl.sv
hw/mm_ctrl_top.sv
verification/tb_clock_gen.sv
verification/mm_ctrl_tb.sv

/* Makefile */
# Verilator flow for the matrix-multiply control sequencer

VERILATOR  ?= verilator
FILELIST   ?= mm_ctrl_top.f
RTL_TOP    ?= mm_ctrl_top
TB_TOP     ?= mm_ctrl_tb
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing -Wno-fatal
PASS_TEXT  ?= PASS: all tests

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(OBJ_DIR) -o V$(TB_TOP)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP) 2>&1)"; \
		echo "$$out"; \
		echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
